/* hw/cpuDefs_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// -----------------------------------------------
// Datapath widths
// -----------------------------------------------
`define CPU_WORD_W      16
`define CPU_BYTE_W      8
`define CPU_ADDR_W      16
`define CPU_FLAGS_W     12

// -----------------------------------------------
// Reset values
// -----------------------------------------------
`define CPU_IP_RESET    16'hFFF0    // First opcode fetched from here
`define CPU_AX_RESET    16'h8185
`define CPU_CX_RESET    16'h1245
`define CPU_DX_RESET    16'h64EA
`define CPU_BX_RESET    16'hE004
`define CPU_SI_RESET    16'h1234
`define CPU_FLAGS_RESET 12'h002     // Bit 1 always reads one

// Flag bit positions in the flags word
`define FLAG_CF         0
`define FLAG_PF         2
`define FLAG_AF         4
`define FLAG_ZF         6
`define FLAG_SF         7
`define FLAG_IF         9
`define FLAG_DF         10
`define FLAG_OF         11

`define OP_HLT          8'hF4       // Stops the sequencer

`endif

/* hw/cpuPkg.sv */
`include "cpuDefs_defs.svh"

package cpuPkg;

    // Plain vectors with a meaning
    typedef logic [`CPU_WORD_W-1:0]  word_t;
    typedef logic [`CPU_BYTE_W-1:0]  byte_t;
    typedef logic [`CPU_ADDR_W-1:0]  addr_t;
    typedef logic [`CPU_FLAGS_W-1:0] flags_t;
    typedef logic [2:0]              regSel_t;    // AX..DI or AL..BH

    // ALU operation, same code as opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_OR  = 3'd1,
        ALU_ADC = 3'd2,
        ALU_SBB = 3'd3,
        ALU_AND = 3'd4,
        ALU_SUB = 3'd5,
        ALU_XOR = 3'd6,
        ALU_CMP = 3'd7
    } aluOp_t;

    // Decode and execute sequencer
    typedef enum logic [3:0] {
        DECODE,     // Wait for opcode byte
        MODRM,      // Wait for ModRM byte
        READLO,     // rm operand, register or low memory byte
        READHI,     // High memory byte
        EXEC,       // ALU and register write
        IMMLO,      // Immediate low byte
        IMMHI,      // Immediate high byte
        WRITELO,    // Store low byte
        WRITEHI,    // Store high byte
        HALT
    } execState_t;

    // One byte access on the external bus
    typedef struct packed {
        addr_t addr;
        byte_t wdata;
        logic  write;
    } memCmd_t;

endpackage

/* hw/regFile.sv */
`timescale 1ns/10ps
`include "cpuDefs_defs.svh"

module regFile (
    input  logic            clk25,
    input  logic            rst,
    input  cpuPkg::regSel_t rdSel,
    input  logic            rdWide,
    output cpuPkg::word_t   rdData,
    input  logic            wrEn,
    input  cpuPkg::regSel_t wrSel,
    input  logic            wrWide,
    input  cpuPkg::word_t   wrData,
    input  cpuPkg::regSel_t eaRm,
    output cpuPkg::addr_t   eaAddr
);
    import cpuPkg::*;

    localparam regSel_t REG_BX = 3'd3;
    localparam regSel_t REG_BP = 3'd5;
    localparam regSel_t REG_SI = 3'd6;
    localparam regSel_t REG_DI = 3'd7;

    word_t   gpr [8];           // AX CX DX BX SP BP SI DI
    regSel_t rdLow;             // Byte views 4..7 live in the high half of 0..3
    regSel_t wrLow;

    assign rdLow = {1'b0, rdSel[1:0]};
    assign wrLow = {1'b0, wrSel[1:0]};

    always_ff @(posedge clk25) begin
        if (rst) begin
            gpr[0] <= `CPU_AX_RESET;
            gpr[1] <= `CPU_CX_RESET;
            gpr[2] <= `CPU_DX_RESET;
            gpr[3] <= `CPU_BX_RESET;
            gpr[4] <= '0;
            gpr[5] <= '0;
            gpr[6] <= `CPU_SI_RESET;
            gpr[7] <= '0;
        end else if (wrEn) begin
            if (wrWide)
                gpr[wrSel] <= wrData;
            else if (wrSel[2])
                gpr[wrLow][15:8] <= wrData[7:0];   // AH..BH
            else
                gpr[wrLow][7:0] <= wrData[7:0];    // AL..BL
        end
    end

    // Narrow reads come back zero-extended
    always_comb begin
        if (rdWide)
            rdData = gpr[rdSel];
        else if (rdSel[2])
            rdData = {8'h00, gpr[rdLow][15:8]};
        else
            rdData = {8'h00, gpr[rdLow][7:0]};
    end

    // mod 00 effective address
    always_comb begin
        case (eaRm)
            3'd0:    eaAddr = gpr[REG_BX] + gpr[REG_SI];
            3'd1:    eaAddr = gpr[REG_BX] + gpr[REG_DI];
            3'd2:    eaAddr = gpr[REG_BP] + gpr[REG_SI];
            3'd3:    eaAddr = gpr[REG_BP] + gpr[REG_DI];
            3'd4:    eaAddr = gpr[REG_SI];
            3'd5:    eaAddr = gpr[REG_DI];
            3'd6:    eaAddr = gpr[REG_BP];   // Direct address form not decoded
            default: eaAddr = gpr[REG_BX];
        endcase
    end

endmodule

/* hw/aluUnit.sv */
`timescale 1ns/10ps
`include "cpuDefs_defs.svh"

module aluUnit (
    input  cpuPkg::aluOp_t op,
    input  logic           wide,
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    input  cpuPkg::flags_t flagsIn,
    output cpuPkg::word_t  result,
    output cpuPkg::flags_t flagsOut
);
    import cpuPkg::*;

    word_t       opA;           // Operands cut to the active width
    word_t       opB;
    logic [16:0] full;          // Result plus carry or borrow
    logic        carryIn;
    logic        isSub;         // SBB SUB CMP
    logic        arith;         // Add and subtract family
    logic        signA;
    logic        signB;
    logic        signR;
    logic        ovf;

    assign opA     = wide ? a : {8'h00, a[7:0]};
    assign opB     = wide ? b : {8'h00, b[7:0]};
    assign carryIn = flagsIn[`FLAG_CF];

    always_comb begin
        case (op)
            ALU_ADD: full = {1'b0, opA} + {1'b0, opB};
            ALU_ADC: full = {1'b0, opA} + {1'b0, opB} + 17'(carryIn);
            ALU_SBB: full = {1'b0, opA} - {1'b0, opB} - 17'(carryIn);
            ALU_OR:  full = {1'b0, opA | opB};
            ALU_AND: full = {1'b0, opA & opB};
            ALU_XOR: full = {1'b0, opA ^ opB};
            default: full = {1'b0, opA} - {1'b0, opB};     // SUB and CMP
        endcase
    end

    assign isSub = op inside {ALU_SBB, ALU_SUB, ALU_CMP};
    assign arith = isSub || op == ALU_ADD || op == ALU_ADC;

    // Sign bits at the active width
    assign signA = wide ? opA[15] : opA[7];
    assign signB = wide ? opB[15] : opB[7];
    assign signR = wide ? full[15] : full[7];

    // Signed overflow
    assign ovf = isSub ? (signA ^ signB) & (signA ^ signR)
                       : ~(signA ^ signB) & (signA ^ signR);

    assign result = wide ? full[15:0] : {8'h00, full[7:0]};

    always_comb begin
        flagsOut    = flagsIn;      // TF IF DF kept
        flagsOut[1] = 1'b1;         // Fixed one
        flagsOut[3] = 1'b0;
        flagsOut[5] = 1'b0;
        flagsOut[`FLAG_CF] = arith & (wide ? full[16] : full[8]);
        flagsOut[`FLAG_OF] = arith & ovf;
        // Nibble carry for arithmetic and plain bit 4 for logic ops
        flagsOut[`FLAG_AF] = arith ? (opA[4] ^ opB[4] ^ full[4]) : full[4];
        flagsOut[`FLAG_ZF] = wide ? (full[15:0] == 16'h0000) : (full[7:0] == 8'h00);
        flagsOut[`FLAG_SF] = signR;
        flagsOut[`FLAG_PF] = ~^full[7:0];   // Even parity of low byte
    end

endmodule

/* hw/fetchUnit.sv */
`timescale 1ns/10ps
`include "cpuDefs_defs.svh"

module fetchUnit (
    input  logic          clk25,
    input  logic          rst,
    input  logic          fetchTake,
    output cpuPkg::byte_t fetchByte,
    output logic          fetchValid,
    output logic          fetchReq,
    output cpuPkg::addr_t fetchAddr,
    input  logic          fetchAck,
    input  cpuPkg::byte_t busRdata
);
    import cpuPkg::*;

    addr_t ip;                  // Address of the byte in or headed for the buffer
    logic  ackWait;             // Byte captured and ack not yet low

    assign fetchAddr = ip;

    always_ff @(posedge clk25) begin
        if (rst) begin
            ip         <= `CPU_IP_RESET;
            fetchValid <= 1'b0;
            fetchReq   <= 1'b0;
            ackWait    <= 1'b0;
        end else if (fetchTake && fetchValid) begin
            fetchValid <= 1'b0;
            ip         <= ip + 1'b1;
            fetchReq   <= 1'b1;             // Refill from the next address
        end else if (fetchReq && fetchAck) begin
            fetchByte  <= busRdata;         // Data valid while ack is high
            fetchReq   <= 1'b0;
            ackWait    <= 1'b1;
        end else if (ackWait && !fetchAck) begin
            ackWait    <= 1'b0;
            fetchValid <= 1'b1;             // Handshake closed
        end else if (!fetchValid && !fetchReq && !ackWait) begin
            fetchReq   <= 1'b1;             // First fill after reset
        end
    end

endmodule

/* hw/memArbiter.sv */
`timescale 1ns/10ps

module memArbiter (
    input  logic            clk25,
    input  logic            rst,
    input  logic            fetchReq,
    input  cpuPkg::addr_t   fetchAddr,
    output logic            fetchAck,
    input  logic            dataReq,
    input  cpuPkg::memCmd_t dataCmd,
    output logic            dataAck,
    output logic            busReq,
    output cpuPkg::memCmd_t busCmd,
    input  logic            busAck
);
    import cpuPkg::*;

    logic    ownFetch;          // Bus held by the fetch side
    logic    ownData;           // Bus held by the data side
    memCmd_t fetchCmd;

    // Fetches are always byte reads
    assign fetchCmd = '{addr: fetchAddr, wdata: '0, write: 1'b0};

    // ---------------------------------------------
    // Forwarding once an owner is held
    // ---------------------------------------------
    assign busReq   = ownData ? dataReq : (ownFetch & fetchReq);
    assign busCmd   = ownData ? dataCmd : fetchCmd;
    assign fetchAck = ownFetch & busAck;        // Only the owner sees ack
    assign dataAck  = ownData & busAck;

    // ---------------------------------------------
    // Owner selection
    // ---------------------------------------------
    always_ff @(posedge clk25) begin
        if (rst) begin
            ownFetch <= 1'b0;
            ownData  <= 1'b0;
        end else if (!busReq && !busAck) begin
            // Bus idle so the last owner is finished
            ownData  <= dataReq;                // Data has priority
            ownFetch <= fetchReq & ~dataReq;
        end
    end

endmodule

/* hw/execCore.sv */
`timescale 1ns/10ps
`include "cpuDefs_defs.svh"

module execCore (
    input  logic            clk25,
    input  logic            rst,
    input  cpuPkg::byte_t   fetchByte,
    input  logic            fetchValid,
    output logic            fetchTake,
    output logic            dataReq,
    output cpuPkg::memCmd_t dataCmd,
    input  logic            dataAck,
    input  cpuPkg::byte_t   busRdata,
    output logic            halted,
    output cpuPkg::flags_t  cpuFlags
);
    import cpuPkg::*;

    execState_t state;
    byte_t      opcode;
    byte_t      modrm;
    word_t      op1;            // Destination operand
    word_t      op2;            // Source operand
    word_t      res;            // Result held for the store
    logic       dataWait;       // Request dropped and ack still high

    // Fields of the held opcode
    logic isAlu, isAluImm, isMovImm, isMovRm, isCmp;
    logic wide, dir, modReg, memDest;

    regSel_t rdSel;
    regSel_t wrSel;
    word_t   rdData;
    word_t   aluRes;
    word_t   result;
    addr_t   eaAddr;
    flags_t  aluFlags;
    memCmd_t nextCmd;
    logic    wrEn;
    logic    memState, hiPhase, byteAck, byteDone;

    assign isAlu    = opcode[7:6] == 2'b00;
    assign isAluImm = isAlu && opcode[2];               // AL/AX with immediate
    assign isMovImm = opcode[7:4] == 4'hB;
    assign isMovRm  = opcode[7:2] == 6'b100010;
    assign isCmp    = isAlu && aluOp_t'(opcode[5:3]) == ALU_CMP;
    assign wide     = isMovImm ? opcode[3] : opcode[0];
    assign dir      = opcode[1];                        // 1 means reg is destination
    assign modReg   = modrm[7:6] == 2'b11;
    assign memDest  = !isAluImm && !isMovImm && !dir && !modReg;

    assign result = isAlu ? aluRes : op2;               // MOV passes the source
    assign halted = state == HALT;
    assign wrEn   = state == EXEC && !memDest && !isCmp;

    // Opcode stream consumed only where a byte is expected
    assign fetchTake = fetchValid
                     && state inside {DECODE, MODRM, IMMLO, IMMHI};

    always_comb begin
        rdSel = modrm[2:0];                             // rm register
        if (state == MODRM)
            rdSel = fetchByte[5:3];                     // reg field off the stream
        else if (state == IMMLO)
            rdSel = 3'd0;                               // AL/AX
    end

    always_comb begin
        if (isMovImm)
            wrSel = opcode[2:0];
        else if (isAluImm)
            wrSel = 3'd0;
        else if (dir)
            wrSel = modrm[5:3];
        else
            wrSel = modrm[2:0];
    end

    // -----------------------------------------------
    // Byte access handshake
    // -----------------------------------------------
    assign memState = state inside {READHI, WRITELO, WRITEHI} || (state == READLO && !modReg);
    assign hiPhase  = state == READHI || state == WRITEHI;
    assign byteAck  = dataReq && dataAck;               // Read data valid now
    assign byteDone = dataWait && !dataAck;             // Four phases complete

    always_comb begin
        nextCmd.addr  = eaAddr + addr_t'(hiPhase);      // Low byte first
        nextCmd.wdata = hiPhase ? res[15:8] : res[7:0];
        nextCmd.write = state == WRITELO || state == WRITEHI;
    end

    regFile u_regFile (
        .clk25  (clk25),
        .rst    (rst),
        .rdSel  (rdSel),
        .rdWide (wide),
        .rdData (rdData),
        .wrEn   (wrEn),
        .wrSel  (wrSel),
        .wrWide (wide),
        .wrData (result),
        .eaRm   (modrm[2:0]),
        .eaAddr (eaAddr)
    );

    aluUnit u_aluUnit (
        .op       (aluOp_t'(opcode[5:3])),
        .wide     (wide),
        .a        (op1),
        .b        (op2),
        .flagsIn  (cpuFlags),
        .result   (aluRes),
        .flagsOut (aluFlags)
    );

    // -----------------------------------------------
    // Sequencer
    // -----------------------------------------------
    always_ff @(posedge clk25) begin
        if (rst) begin
            state    <= DECODE;
            cpuFlags <= `CPU_FLAGS_RESET;
            dataReq  <= 1'b0;
            dataWait <= 1'b0;
            dataCmd  <= '0;
        end else begin
            if (memState && !dataReq && !dataWait) begin
                dataReq <= 1'b1;
                dataCmd <= nextCmd;                     // Stable before req rises
            end
            if (byteAck) begin
                dataReq  <= 1'b0;
                dataWait <= 1'b1;
            end
            if (byteDone)
                dataWait <= 1'b0;

            case (state)
                DECODE: if (fetchValid) begin
                    opcode <= fetchByte;
                    casez (fetchByte)
                        8'b00???0??, 8'b100010??: state <= MODRM;
                        8'b00???10?, 8'b1011????: state <= IMMLO;
                        8'hF5:       cpuFlags[`FLAG_CF] <= ~cpuFlags[`FLAG_CF];   // CMC
                        8'b1111100?: cpuFlags[`FLAG_CF] <= fetchByte[0];  // CLC STC
                        8'b1111101?: cpuFlags[`FLAG_IF] <= fetchByte[0];  // CLI STI
                        8'b1111110?: cpuFlags[`FLAG_DF] <= fetchByte[0];  // CLD STD
                        `OP_HLT:     state <= HALT;
                        default:     state <= DECODE;           // One-byte no-op
                    endcase
                end
                MODRM: if (fetchValid) begin
                    modrm <= fetchByte;
                    if (dir)
                        op1 <= rdData;
                    else
                        op2 <= rdData;
                    // Plain store skips the old rm value
                    state <= (isMovRm && !dir) ? EXEC : READLO;
                end
                READLO: begin
                    if (modReg) begin
                        if (dir)
                            op2 <= rdData;
                        else
                            op1 <= rdData;
                        state <= EXEC;
                    end else begin
                        if (byteAck && dir)
                            op2 <= {8'h00, busRdata};
                        if (byteAck && !dir)
                            op1 <= {8'h00, busRdata};
                        if (byteDone)
                            state <= wide ? READHI : EXEC;
                    end
                end
                READHI: begin
                    if (byteAck && dir)
                        op2[15:8] <= busRdata;
                    if (byteAck && !dir)
                        op1[15:8] <= busRdata;
                    if (byteDone)
                        state <= EXEC;
                end
                IMMLO: if (fetchValid) begin
                    op1   <= rdData;                    // Accumulator
                    op2   <= {8'h00, fetchByte};
                    state <= wide ? IMMHI : EXEC;
                end
                IMMHI: if (fetchValid) begin
                    op2[15:8] <= fetchByte;
                    state     <= EXEC;
                end
                EXEC: begin
                    if (isAlu)
                        cpuFlags <= aluFlags;
                    res   <= result;
                    state <= (memDest && !isCmp) ? WRITELO : DECODE;
                end
                WRITELO: if (byteDone) state <= wide ? WRITEHI : DECODE;
                WRITEHI: if (byteDone) state <= DECODE;
                default: state <= HALT;                 // Held until reset
            endcase
        end
    end

endmodule

/* hw/cpuTop.sv */
`timescale 1ns/10ps

module cpuTop (
    input  logic            clk25,
    input  logic            rst,
    output logic            busReq,
    output cpuPkg::memCmd_t busCmd,
    input  logic            busAck,
    input  cpuPkg::byte_t   busRdata,
    output logic            halted,
    output cpuPkg::flags_t  cpuFlags
);
    import cpuPkg::*;

    // Opcode stream
    byte_t   fetchByte;
    logic    fetchValid;
    logic    fetchTake;

    // Requester ports into the arbiter
    logic    fetchReq;
    logic    fetchAck;
    addr_t   fetchAddr;
    logic    dataReq;
    logic    dataAck;
    memCmd_t dataCmd;

    fetchUnit u_fetchUnit (
        .clk25      (clk25),
        .rst        (rst),
        .fetchTake  (fetchTake),
        .fetchByte  (fetchByte),
        .fetchValid (fetchValid),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .fetchAck   (fetchAck),
        .busRdata   (busRdata)
    );

    execCore u_execCore (
        .clk25      (clk25),
        .rst        (rst),
        .fetchByte  (fetchByte),
        .fetchValid (fetchValid),
        .fetchTake  (fetchTake),
        .dataReq    (dataReq),
        .dataCmd    (dataCmd),
        .dataAck    (dataAck),
        .busRdata   (busRdata),
        .halted     (halted),
        .cpuFlags   (cpuFlags)
    );

    memArbiter u_memArbiter (
        .clk25      (clk25),
        .rst        (rst),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .fetchAck   (fetchAck),
        .dataReq    (dataReq),
        .dataCmd    (dataCmd),
        .dataAck    (dataAck),
        .busReq     (busReq),
        .busCmd     (busCmd),
        .busAck     (busAck)
    );

endmodule

/* test/cpuChecker.sv */
`timescale 1ns/10ps

module cpuChecker #(
    parameter int MAX_WRITES = 64
) (
    input  logic                        clk25,
    input  logic                        rst,
    input  logic                        busReq,
    input  cpuPkg::memCmd_t             busCmd,
    input  logic                        busAck,
    input  logic                        halted,
    input  cpuPkg::flags_t              cpuFlags,
    input  logic [MAX_WRITES-1:0][23:0] expWrites,
    input  int                          expCount,
    input  cpuPkg::flags_t              expFlags,
    output int                          errCount,
    output int                          writesSeen,
    output logic                        checkDone
);
    import cpuPkg::*;

    logic    prevReq;
    logic    prevAck;
    logic    prevHalted;
    memCmd_t prevCmd;           // Command seen while req was high

    task automatic compareWrite;
        addr_t expAddr;
        byte_t expData;
        if (writesSeen >= expCount) begin
            $display("Unexpected extra write to %h", busCmd.addr);
            errCount++;
        end else begin
            expAddr = expWrites[writesSeen][23:8];
            expData = expWrites[writesSeen][7:0];
            if (busCmd.addr !== expAddr) begin
                $display("CHECK FAILED busCmd.addr: got %h expected %h", busCmd.addr, expAddr);
                errCount++;
            end
            if (busCmd.wdata !== expData) begin
                $display("CHECK FAILED busCmd.wdata: got %h expected %h",
                         busCmd.wdata, expData);
                errCount++;
            end
        end
        writesSeen++;
    endtask

    // Posedge sampling, bus driven on the other edge
    always @(posedge clk25) begin
        if (rst) begin
            prevReq    <= 1'b0;
            prevAck    <= 1'b0;
            prevHalted <= 1'b0;
            prevCmd    <= '0;
            errCount   = 0;
            writesSeen = 0;
            checkDone  = 1'b0;
        end else begin
            if (busReq && busAck && !prevAck && busCmd.write)
                compareWrite();
            // ----------------------------------------------
            // Four-phase order
            // ----------------------------------------------
            if (prevReq && !busReq && !prevAck) begin
                $display("Bus request dropped before acknowledge");
                errCount++;
            end
            if (!prevReq && busReq && prevAck) begin
                $display("Bus request rose while acknowledge was still high");
                errCount++;
            end
            if (prevReq && busReq && busCmd !== prevCmd) begin
                $display("Bus command changed while request was held");
                errCount++;
            end
            if (halted && !prevHalted) begin
                if (cpuFlags !== expFlags) begin
                    $display("CHECK FAILED cpuFlags: got %h expected %h", cpuFlags, expFlags);
                    errCount++;
                end
                if (writesSeen != expCount) begin
                    $display("Wrong number of writes at halt: saw %0d, expected %0d",
                             writesSeen, expCount);
                    errCount++;
                end
                checkDone = 1'b1;
            end
            prevReq    <= busReq;
            prevAck    <= busAck;
            prevHalted <= halted;
            prevCmd    <= busCmd;
        end
    end

endmodule

/* test/cpuTb.sv */
`timescale 1ns/10ps

module cpuTb;
    import cpuPkg::*;

    localparam int MAX_WRITES = 64;
    localparam int BUS_TMO    = 2000;       // Cycles allowed for one bus phase
    localparam int RUN_TMO    = 20000;      // Cycles allowed until halt

    logic    clk25 = 1'b0;
    logic    rst;
    logic    busReq;
    memCmd_t busCmd;
    logic    busAck;
    byte_t   busRdata;
    logic    halted;
    flags_t  cpuFlags;

    byte_t                       mem [0:65535];     // External byte memory
    logic [MAX_WRITES-1:0][23:0] expWrites;         // {addr, data} in write order
    int                          expCount;
    flags_t                      expFlags;
    int                          errCount;
    int                          writesSeen;
    logic                        checkDone;
    int                          tbErrors;
    integer                      seed = 36;

    always #4 clk25 = ~clk25;

    cpuTop u_cpuTop (
        .clk25    (clk25),
        .rst      (rst),
        .busReq   (busReq),
        .busCmd   (busCmd),
        .busAck   (busAck),
        .busRdata (busRdata),
        .halted   (halted),
        .cpuFlags (cpuFlags)
    );

    cpuChecker #(.MAX_WRITES(MAX_WRITES)) u_cpuChecker (
        .clk25      (clk25),
        .rst        (rst),
        .busReq     (busReq),
        .busCmd     (busCmd),
        .busAck     (busAck),
        .halted     (halted),
        .cpuFlags   (cpuFlags),
        .expWrites  (expWrites),
        .expCount   (expCount),
        .expFlags   (expFlags),
        .errCount   (errCount),
        .writesSeen (writesSeen),
        .checkDone  (checkDone)
    );

    // Background pattern over the whole address
    task automatic fillMemory;
        logic [15:0] addrVal;
        for (int i = 0; i < 65536; i++) begin
            addrVal = i[15:0];
            mem[i] = addrVal[7:0] ^ addrVal[15:8] ^ 8'hA5;
        end
    endtask

    // ----------------------------------------------
    // Stimulus file with M, W, F records and # comments
    // ----------------------------------------------
    task automatic loadStimulus;
        integer           fd;
        integer           code;
        reg [63:0]        tag;
        reg [8*200-1:0]   rest;
        logic [15:0]      addrVal;
        logic [15:0]      dataVal;
        fd = $fopen("test/cpuStimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/cpuStimulus.txt");
            tbErrors++;
        end else begin
            code = $fscanf(fd, " %s", tag);
            while (code == 1) begin
                if (tag == "M") begin
                    code = $fscanf(fd, " %h %h", addrVal, dataVal);
                    mem[addrVal] = dataVal[7:0];
                end else if (tag == "W") begin
                    code = $fscanf(fd, " %h %h", addrVal, dataVal);
                    if (expCount < MAX_WRITES)
                        expWrites[expCount] = {addrVal, dataVal[7:0]};
                    expCount++;
                end else if (tag == "F") begin
                    code = $fscanf(fd, " %h", dataVal);
                    expFlags = dataVal[11:0];
                end else begin
                    code = $fgets(rest, fd);    // Rest of a comment line
                end
                code = $fscanf(fd, " %s", tag);
            end
            $fclose(fd);
        end
    endtask

    task automatic finishRun;
        $display("Errors: checker %0d, testbench %0d, writes seen %0d of %0d",
                 errCount, tbErrors, writesSeen, expCount);
        if (errCount == 0 && tbErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // ----------------------------------------------
    // Main sequence
    // ----------------------------------------------
    initial begin
        int cycles;
        rst       = 1'b1;
        busAck    = 1'b0;
        busRdata  = '0;
        tbErrors  = 0;
        expCount  = 0;
        expFlags  = '0;
        expWrites = '0;
        fillMemory();
        loadStimulus();
        repeat (2) @(posedge clk25);
        @(negedge clk25);
        rst = 1'b0;
        cycles = 0;
        while (tbErrors == 0 && !halted && cycles < RUN_TMO) begin
            @(negedge clk25);
            cycles++;
        end
        if (tbErrors != 0) begin
            $display("Run stopped before halt");
        end else if (!halted) begin
            $display("Timeout: the CPU never halted");
            tbErrors++;
        end else begin
            cycles = 0;
            while (!checkDone && cycles < 100) begin
                @(negedge clk25);
                cycles++;
            end
            if (!checkDone) begin
                $display("Timeout: the checker never finished its halt checks");
                tbErrors++;
            end
        end
        finishRun();
    end

    // ----------------------------------------------
    // Four-phase memory model, driven on falling edges
    // ----------------------------------------------
    initial begin
        int waitCycles;
        int delay;
        while (tbErrors == 0) begin
            waitCycles = 0;
            while (busReq !== 1'b1 && waitCycles < BUS_TMO) begin
                @(negedge clk25);
                waitCycles++;
            end
            if (busReq !== 1'b1) begin
                $display("Timeout: no bus request arrived");
                tbErrors++;
            end else begin
                delay = {$random(seed)} % 4;    // 0..3 cycles before ack
                repeat (delay) @(negedge clk25);
                if (busCmd.write)
                    mem[busCmd.addr] = busCmd.wdata;
                else
                    busRdata = mem[busCmd.addr];
                busAck = 1'b1;
                waitCycles = 0;
                while (busReq && waitCycles < BUS_TMO) begin
                    @(negedge clk25);
                    waitCycles++;
                end
                if (busReq) begin
                    $display("Timeout: bus request never dropped after ack");
                    tbErrors++;
                end else begin
                    delay = {$random(seed)} % 4;    // Ack held 0..3 cycles past req
                    repeat (delay) @(negedge clk25);
                    busAck = 1'b0;
                end
            end
        end
    end

endmodule

/* filelist.f */
+incdir+hw
hw/cpuPkg.sv
hw/regFile.sv
hw/aluUnit.sv
hw/fetchUnit.sv
hw/memArbiter.sv
hw/execCore.sv
hw/cpuTop.sv
test/cpuChecker.sv
test/cpuTb.sv

/* test/cpuStimulus.txt */
# M addr byte = memory image, W addr byte = expected write in order
# F flags = expected final flags word after HLT, all values hex
M FFF0 BB M FFF1 00 M FFF2 40   # MOV BX,4000
M FFF3 B4 M FFF4 5A             # MOV AH,5A
M FFF5 B5 M FFF6 C3             # MOV CH,C3
M FFF7 89 M FFF8 07             # MOV [BX],AX
M FFF9 01 M FFFA C8             # ADD AX,CX
M FFFB 13 M FFFC D1             # ADC DX,CX
M FFFD 29 M FFFE D0             # SUB AX,DX
M FFFF 1B M 0000 C1             # SBB AX,CX
M 0001 09 M 0002 C8             # OR AX,CX
M 0003 21 M 0004 D0             # AND AX,DX
M 0005 31 M 0006 C8             # XOR AX,CX
M 0007 39 M 0008 C8             # CMP AX,CX
M 0009 89 M 000A 00             # MOV [BX+SI],AX
M 000B 00 M 000C E9             # ADD CL,CH
M 000D 12 M 000E C5             # ADC AL,CH
M 000F 2A M 0010 C1             # SUB AL,CL
M 0011 18 M 0012 E0             # SBB AL,AH
M 0013 08 M 0014 E8             # OR AL,CH
M 0015 20 M 0016 C8             # AND AL,CL
M 0017 30 M 0018 E0             # XOR AL,AH
M 0019 38 M 001A C8             # CMP AL,CL
M 001B 89 M 001C 01             # MOV [BX+DI],AX
M 001D 01 M 001E 08             # ADD [BX+SI],CX
M 001F 31 M 0020 0C             # XOR [SI],CX
M 0021 2B M 0022 04             # SUB AX,[SI]
M 0023 05 M 0024 10 M 0025 01   # ADD AX,0110
M 0026 3C M 0027 03             # CMP AL,03
M 0028 34 M 0029 F0             # XOR AL,F0
M 002A 3D M 002B F3 M 002C 18   # CMP AX,18F3
M 002D 89 M 002E 07             # MOV [BX],AX
M 002F F9 M 0030 F5 M 0031 F5   # STC CMC CMC
M 0032 FB M 0033 FD M 0034 FC   # STI STD CLD
M 0035 F4                       # HLT
M 1234 F0 M 1235 0F             # Data word at SI
W 4000 85 W 4001 5A             # AH from MOV imm, AL from reset
W 5234 55 W 5235 E3             # 16-bit ALU chain
W 4000 EB W 4001 E3             # 8-bit ALU chain
W 5234 5D W 5235 A6             # Memory ADD
W 1234 F8 W 1235 CC             # Memory XOR
W 4000 F3 W 4001 18             # Immediate ops, CMP leaves AX
F 247
